// File: bench/lc3b_exec_checker.sv
module lc3b_exec_checker (
    input logic        clk,
    input logic        retire_valid,
    input logic [15:0] retire_pc,
    input logic        retire_reg_write,
    input logic [2:0]  retire_dest,
    input logic [15:0] retire_data,
    input logic [2:0]  retire_cc
);
    timeunit 1ns;
    timeprecision 1ps;

    // record layout {wr, dest[2:0], data[15:0], cc[2:0], pc[15:0]}
    string       name_q [$];
    logic [38:0] exp_q [$];
    int          checked = 0;
    int          failures = 0;
    string       cur_name;
    logic [38:0] cur_exp;
    logic [38:0] act;

    function automatic string fmt_rec(input logic [38:0] rec);
        return $sformatf("wr=%b dest=%0d data=%h cc=%b pc=%h",
                         rec[38], rec[37:35], rec[34:19], rec[18:16], rec[15:0]);
    endfunction

    task automatic push_expect(input string name, input logic wr, input logic [2:0] dest,
                               input logic [15:0] data, input logic [2:0] cc,
                               input logic [15:0] pc);
        name_q.push_back(name);
        exp_q.push_back({wr, dest, data, cc, pc});
    endtask

    task automatic report_counts();
        $display("tests run %0d, passed %0d, failed %0d",
                 checked, checked - failures, failures);
    endtask

    task automatic compare_retire();
        if (!retire_valid) begin
            $display("test %s: retire_valid did not rise after the instruction strobe",
                     cur_name);
            failures++;
        end else begin
            act = {retire_reg_write, retire_dest, retire_data, retire_cc, retire_pc};
            if (!cur_exp[38])
                act[37:35] = cur_exp[37:35];    // dest only matters on a write
            if (act !== cur_exp) begin
                $display("CHECK FAILED %s: expected %s, actual %s",
                         cur_name, fmt_rec(cur_exp), fmt_rec(act));
                failures++;
            end else begin
                $display("ok    %s", cur_name);
            end
        end
        checked++;
    endtask

    // strobe edge picks up the record, outputs are settled by the falling edge
    initial begin
        forever begin
            @(posedge clk);
            if (exp_q.size() > 0) begin
                cur_name = name_q.pop_front();
                cur_exp  = exp_q.pop_front();
                @(negedge clk);
                compare_retire();
            end
        end
    end

endmodule : lc3b_exec_checker

// File: bench/lc3b_exec_tb.sv
module lc3b_exec_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int         CLK_PERIOD   = 40;
    localparam int         RESET_CYCLES = 10;
    localparam int         MAX_TESTS    = 32;
    localparam logic [2:0] CC_N         = 3'b100;
    localparam logic [2:0] CC_Z         = 3'b010;
    localparam logic [2:0] CC_P         = 3'b001;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [15:0] instr;
    logic        retire_valid;
    logic [15:0] retire_pc;
    logic        retire_reg_write;
    logic [2:0]  retire_dest;
    logic [15:0] retire_data;
    logic [2:0]  retire_cc;

    string       test_name [MAX_TESTS];
    logic [15:0] test_instr [MAX_TESTS];
    logic        exp_wr [MAX_TESTS];
    logic [2:0]  exp_dest [MAX_TESTS];
    logic [15:0] exp_data [MAX_TESTS];
    logic [2:0]  exp_cc [MAX_TESTS];
    logic [15:0] exp_pc [MAX_TESTS];
    int          n_tests;
    logic [31:0] rnd_word;
    logic [4:0]  rnd_imm;
    logic [15:0] rnd_sum;

    lc3b_exec #(
        .MEM_WORDS (64)
    ) dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .instr_valid      (instr_valid),
        .instr            (instr),
        .retire_valid     (retire_valid),
        .retire_pc        (retire_pc),
        .retire_reg_write (retire_reg_write),
        .retire_dest      (retire_dest),
        .retire_data      (retire_data),
        .retire_cc        (retire_cc)
    );

    lc3b_exec_checker chk0 (
        .clk              (clk),
        .retire_valid     (retire_valid),
        .retire_pc        (retire_pc),
        .retire_reg_write (retire_reg_write),
        .retire_dest      (retire_dest),
        .retire_data      (retire_data),
        .retire_cc        (retire_cc)
    );

    function automatic logic [2:0] nzp_of(input logic [15:0] w);
        if (w[15])
            return CC_N;
        else if (w == 16'h0000)
            return CC_Z;
        return CC_P;
    endfunction

    task automatic add_test(input string name, input logic [15:0] iw, input logic wr,
                            input logic [2:0] dest, input logic [15:0] data,
                            input logic [2:0] cc, input logic [15:0] pc);
        test_name[n_tests]  = name;
        test_instr[n_tests] = iw;
        exp_wr[n_tests]     = wr;
        exp_dest[n_tests]   = dest;
        exp_data[n_tests]   = data;
        exp_cc[n_tests]     = cc;
        exp_pc[n_tests]     = pc;
        n_tests++;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        n_tests     = 0;
        rnd_word    = $urandom(80);    // seeds the generator
        rnd_imm     = rnd_word[4:0];
        rnd_sum     = 16'd7 + {{11{rnd_imm[4]}}, rnd_imm};    // r1 holds 7 by then

        // name, instr, wr, dest, data, cc, pc after
        add_test("br_never_reset", 16'h0000, 1'b0, 3'd0, 16'h0000, CC_Z, 16'h0002);
        add_test("and_clear_r1", 16'h5260, 1'b1, 3'd1, 16'h0000, CC_Z, 16'h0004);
        add_test("add_imm_r1", 16'h1267, 1'b1, 3'd1, 16'h0007, CC_P, 16'h0006);
        add_test("add_imm_neg_r2", 16'h14bd, 1'b1, 3'd2, 16'hfffd, CC_N, 16'h0008);
        add_test("add_reg_r3", 16'h1642, 1'b1, 3'd3, 16'h0004, CC_P, 16'h000a);
        add_test("add_rand_imm_r4", 16'h1860 | {11'b0, rnd_imm}, 1'b1, 3'd4, rnd_sum,
                 nzp_of(rnd_sum), 16'h000c);
        add_test("not_r5", 16'h9abf, 1'b1, 3'd5, 16'h0002, CC_P, 16'h000e);
        add_test("sll_3", 16'hdc43, 1'b1, 3'd6, 16'h0038, CC_P, 16'h0010);
        add_test("srl_4", 16'hdc94, 1'b1, 3'd6, 16'h0fff, CC_P, 16'h0012);
        add_test("sra_4", 16'hdcb4, 1'b1, 3'd6, 16'hffff, CC_N, 16'h0014);
        add_test("lea_r0", 16'he005, 1'b1, 3'd0, 16'h0020, CC_P, 16'h0016);
        add_test("str_r2", 16'h7403, 1'b0, 3'd2, 16'hfffd, CC_P, 16'h0018);
        add_test("ldr_r1", 16'h6203, 1'b1, 3'd1, 16'hfffd, CC_N, 16'h001a);
        add_test("brn_taken", 16'h0802, 1'b0, 3'd0, 16'h0000, CC_N, 16'h0020);
        add_test("brzp_not_taken", 16'h0604, 1'b0, 3'd0, 16'h0000, CC_N, 16'h0022);
        add_test("and_clear_r5", 16'h5b60, 1'b1, 3'd5, 16'h0000, CC_Z, 16'h0024);
        add_test("brz_back_taken", 16'h05fe, 1'b0, 3'd0, 16'h0000, CC_Z, 16'h0022);
        add_test("jmp_r3", 16'hc0c0, 1'b0, 3'd0, 16'h0000, CC_Z, 16'h0004);
        add_test("jsr_link", 16'h4808, 1'b1, 3'd7, 16'h0006, CC_Z, 16'h0016);
        add_test("jsrr_r0", 16'h4000, 1'b1, 3'd7, 16'h0018, CC_Z, 16'h0020);
        add_test("trap_no_effect", 16'hf025, 1'b0, 3'd0, 16'h0000, CC_Z, 16'h0022);
        add_test("ldb_no_effect", 16'h2203, 1'b0, 3'd0, 16'h0000, CC_Z, 16'h0024);
        add_test("r1_kept", 16'h1460, 1'b1, 3'd2, 16'hfffd, CC_N, 16'h0026);

        fork
            begin
                #((n_tests + RESET_CYCLES + 20) * CLK_PERIOD);
                $display("timeout: not every instruction retired in time");
                $display(">>> FAIL");
                $finish;
            end
        join_none

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < n_tests; i++) begin
            @(negedge clk);
            instr       = test_instr[i];
            instr_valid = 1'b1;    // back-to-back strobes
            chk0.push_expect(test_name[i], exp_wr[i], exp_dest[i], exp_data[i],
                             exp_cc[i], exp_pc[i]);
        end
        @(negedge clk);
        instr_valid = 1'b0;
        instr       = '0;

        wait (chk0.checked == n_tests);
        chk0.report_counts();
        if (chk0.failures == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : lc3b_exec_tb

// File: hw/control_rom.sv
module control_rom (
    input  lc3b_types::lc3b_word         instr,
    output lc3b_types::lc3b_control_word ctrl
);

    lc3b_types::lc3b_opcode opcode;

    assign opcode = lc3b_types::lc3b_opcode'(instr[15:12]);

    always_comb begin
        // fetch side
        ctrl.conditional_branch = 1'b0;
        ctrl.pc_mux_sel         = lc3b_types::lc3b_pc_mux_sel_pc_plus2;
        ctrl.pc_adder_mux_sel   = lc3b_types::lc3b_pc_adder_mux_sel_offset9;
        // operand and execute
        ctrl.sr2_mux_sel        = lc3b_types::lc3b_sr2_mux_sel_sr2;
        ctrl.alu_mux_sel        = lc3b_types::lc3b_alu_mux_sel_sr2;
        ctrl.alu_op             = lc3b_types::lc3b_alu_op_pass;
        // memory and write-back
        ctrl.cc_load            = 1'b0;
        ctrl.mem_write          = 1'b0;
        ctrl.data_mux_sel       = lc3b_types::lc3b_data_mux_sel_alu;
        ctrl.dest_mux_sel       = lc3b_types::lc3b_dest_mux_sel_dest;
        ctrl.regfile_load       = 1'b0;

        case (opcode)
            lc3b_types::op_add: begin
                if (instr[5])
                    ctrl.alu_mux_sel = lc3b_types::lc3b_alu_mux_sel_imm5;
                ctrl.alu_op       = lc3b_types::lc3b_alu_op_add;
                ctrl.cc_load      = 1'b1;
                ctrl.regfile_load = 1'b1;
            end

            lc3b_types::op_and: begin
                if (instr[5])
                    ctrl.alu_mux_sel = lc3b_types::lc3b_alu_mux_sel_imm5;
                ctrl.alu_op       = lc3b_types::lc3b_alu_op_and;
                ctrl.cc_load      = 1'b1;
                ctrl.regfile_load = 1'b1;
            end

            lc3b_types::op_not: begin
                ctrl.alu_op       = lc3b_types::lc3b_alu_op_not;
                ctrl.cc_load      = 1'b1;
                ctrl.regfile_load = 1'b1;
            end

            lc3b_types::op_shf: begin
                ctrl.alu_mux_sel = lc3b_types::lc3b_alu_mux_sel_imm4;
                if (!instr[4])
                    ctrl.alu_op = lc3b_types::lc3b_alu_op_sll;
                else if (!instr[5])
                    ctrl.alu_op = lc3b_types::lc3b_alu_op_srl;    // logical, zero fill
                else
                    ctrl.alu_op = lc3b_types::lc3b_alu_op_sra;
                ctrl.cc_load      = 1'b1;
                ctrl.regfile_load = 1'b1;
            end

            lc3b_types::op_lea: begin
                ctrl.data_mux_sel = lc3b_types::lc3b_data_mux_sel_pcn;
                ctrl.cc_load      = 1'b1;    // lc-3b lea still sets cc
                ctrl.regfile_load = 1'b1;
            end

            lc3b_types::op_ldr: begin
                ctrl.alu_mux_sel  = lc3b_types::lc3b_alu_mux_sel_offset6_w;
                ctrl.alu_op       = lc3b_types::lc3b_alu_op_add;
                ctrl.data_mux_sel = lc3b_types::lc3b_data_mux_sel_mdr;
                ctrl.cc_load      = 1'b1;
                ctrl.regfile_load = 1'b1;
            end

            lc3b_types::op_str: begin
                ctrl.sr2_mux_sel = lc3b_types::lc3b_sr2_mux_sel_dest;
                ctrl.alu_mux_sel = lc3b_types::lc3b_alu_mux_sel_offset6_w;
                ctrl.alu_op      = lc3b_types::lc3b_alu_op_add;
                ctrl.mem_write   = 1'b1;
            end

            lc3b_types::op_br: begin
                ctrl.conditional_branch = 1'b1;
                ctrl.pc_mux_sel         = lc3b_types::lc3b_pc_mux_sel_pcn;
            end

            lc3b_types::op_jmp: begin
                ctrl.pc_mux_sel = lc3b_types::lc3b_pc_mux_sel_alu;    // base reg via alu pass
            end

            lc3b_types::op_jsr: begin
                if (instr[11]) begin
                    ctrl.pc_mux_sel       = lc3b_types::lc3b_pc_mux_sel_pcn;
                    ctrl.pc_adder_mux_sel = lc3b_types::lc3b_pc_adder_mux_sel_offset11;
                end else begin
                    ctrl.pc_mux_sel = lc3b_types::lc3b_pc_mux_sel_alu;    // jsrr
                end
                ctrl.data_mux_sel = lc3b_types::lc3b_data_mux_sel_pc;
                ctrl.dest_mux_sel = lc3b_types::lc3b_dest_mux_sel_r7;
                ctrl.regfile_load = 1'b1;
            end

            default: begin
                ctrl = '0;    // unknown, byte, indirect and trap
            end
        endcase
    end

    // no decoded instruction both stores and writes a register
    a_no_store_and_load: assert final (!(ctrl.mem_write && ctrl.regfile_load))
        else $error("control word has mem_write and regfile_load together");

endmodule : control_rom

// File: hw/data_memory.sv
module data_memory #(
    parameter int MEM_WORDS = 64
) (
    input  logic                 clk,
    input  logic                 write,
    input  lc3b_types::lc3b_word addr,
    input  lc3b_types::lc3b_word wdata,
    output lc3b_types::lc3b_word rdata
);

    localparam int ADDR_BITS = $clog2(MEM_WORDS);

    lc3b_types::lc3b_word     mem [MEM_WORDS];
    logic [ADDR_BITS-1:0]     word_addr;

    assign word_addr = addr[ADDR_BITS:1];    // byte address, upper bits wrap

    always_ff @(posedge clk) begin
        if (write)
            mem[word_addr] <= wdata;
    end

    assign rdata = mem[word_addr];

endmodule : data_memory

// File: hw/execute_unit.sv
module execute_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         instr_valid,
    input  lc3b_types::lc3b_word         instr,
    input  lc3b_types::lc3b_control_word ctrl,
    input  lc3b_types::lc3b_word         sr1,
    input  lc3b_types::lc3b_word         sr2,
    input  lc3b_types::lc3b_word         mdr,
    input  lc3b_types::lc3b_word         pc,
    input  lc3b_types::lc3b_word         pcn,
    input  lc3b_types::lc3b_nzp          cc_in,
    output lc3b_types::lc3b_reg          sr2_sel,
    output lc3b_types::lc3b_word         mem_addr,
    output lc3b_types::lc3b_word         mem_wdata,
    output logic                         mem_write,
    output logic                         rf_load,
    output lc3b_types::lc3b_reg          rf_dest,
    output lc3b_types::lc3b_word         rf_data,
    output lc3b_types::lc3b_nzp          cc_out,
    output logic                         retire_valid,
    output lc3b_types::lc3b_word         retire_pc,
    output logic                         retire_reg_write,
    output lc3b_types::lc3b_reg          retire_dest,
    output lc3b_types::lc3b_word         retire_data,
    output lc3b_types::lc3b_nzp          retire_cc
);

    lc3b_types::lc3b_word alu_b;
    lc3b_types::lc3b_word alu_out;

    assign sr2_sel = (ctrl.sr2_mux_sel == lc3b_types::lc3b_sr2_mux_sel_dest) ?
                     instr[11:9] : instr[2:0];

    always_comb begin
        case (ctrl.alu_mux_sel)
            lc3b_types::lc3b_alu_mux_sel_sr2:   alu_b = sr2;
            lc3b_types::lc3b_alu_mux_sel_imm5:  alu_b = {{11{instr[4]}}, instr[4:0]};
            lc3b_types::lc3b_alu_mux_sel_imm4:  alu_b = {12'b0, instr[3:0]};    // shift amount
            default:                            alu_b = {{9{instr[5]}}, instr[5:0], 1'b0};
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            lc3b_types::lc3b_alu_op_add: alu_out = sr1 + alu_b;
            lc3b_types::lc3b_alu_op_and: alu_out = sr1 & alu_b;
            lc3b_types::lc3b_alu_op_not: alu_out = ~sr1;
            lc3b_types::lc3b_alu_op_sll: alu_out = sr1 << alu_b[3:0];
            lc3b_types::lc3b_alu_op_srl: alu_out = sr1 >> alu_b[3:0];
            lc3b_types::lc3b_alu_op_sra: alu_out = $signed(sr1) >>> alu_b[3:0];
            default:                     alu_out = sr1;    // pass, used by jmp/jsrr
        endcase
    end

    assign mem_addr  = alu_out;
    assign mem_wdata = sr2;
    assign mem_write = ctrl.mem_write && instr_valid;

    always_comb begin
        case (ctrl.data_mux_sel)
            lc3b_types::lc3b_data_mux_sel_mdr: rf_data = mdr;
            lc3b_types::lc3b_data_mux_sel_pcn: rf_data = pcn;
            lc3b_types::lc3b_data_mux_sel_pc:  rf_data = pc + 16'd2;    // link value
            default:                           rf_data = alu_out;
        endcase
    end

    assign rf_dest = (ctrl.dest_mux_sel == lc3b_types::lc3b_dest_mux_sel_r7) ?
                     3'd7 : instr[11:9];
    assign rf_load = ctrl.regfile_load && instr_valid;

    assign cc_out = rf_data[15] ? 3'b100 : ((rf_data == '0) ? 3'b010 : 3'b001);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid     <= 1'b0;
            retire_reg_write <= 1'b0;
        end else begin
            retire_valid <= instr_valid;
            if (instr_valid)
                retire_reg_write <= rf_load;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            retire_dest <= rf_dest;
            if (ctrl.mem_write)
                retire_data <= sr2;    // store reports its data
            else if (ctrl.regfile_load)
                retire_data <= rf_data;
            else
                retire_data <= '0;
        end
    end

    // pc and cc registers already hold the post-instruction state
    assign retire_pc = pc;
    assign retire_cc = cc_in;

    a_mem_addr_even: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid && (ctrl.mem_write ||
        ctrl.data_mux_sel == lc3b_types::lc3b_data_mux_sel_mdr) |-> !mem_addr[0])
        else $error("word access to odd address %h", mem_addr);

endmodule : execute_unit

// File: hw/lc3b_exec.sv
module lc3b_exec #(
    parameter int MEM_WORDS = 64
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_valid,
    input  lc3b_types::lc3b_word instr,
    output logic                 retire_valid,
    output lc3b_types::lc3b_word retire_pc,
    output logic                 retire_reg_write,
    output lc3b_types::lc3b_reg  retire_dest,
    output lc3b_types::lc3b_word retire_data,
    output lc3b_types::lc3b_nzp  retire_cc
);

    lc3b_types::lc3b_control_word ctrl;
    lc3b_types::lc3b_reg          sr2_sel;
    lc3b_types::lc3b_word         sr1;
    lc3b_types::lc3b_word         sr2;
    lc3b_types::lc3b_word         mem_addr;
    lc3b_types::lc3b_word         mem_wdata;
    logic                         mem_write;
    lc3b_types::lc3b_word         mdr;
    logic                         rf_load;
    lc3b_types::lc3b_reg          rf_dest;
    lc3b_types::lc3b_word         rf_data;
    lc3b_types::lc3b_nzp          cc_new;
    lc3b_types::lc3b_nzp          cc;
    lc3b_types::lc3b_word         pc;
    lc3b_types::lc3b_word         pcn;

    control_rom u_control_rom (
        .instr (instr),
        .ctrl  (ctrl)
    );

    regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (rf_load),
        .dest_addr (rf_dest),
        .sr1_addr  (instr[8:6]),    // base or first source
        .sr2_addr  (sr2_sel),
        .data_in   (rf_data),
        .sr1_out   (sr1),
        .sr2_out   (sr2)
    );

    execute_unit u_execute_unit (
        .clk              (clk),
        .rst_n            (rst_n),
        .instr_valid      (instr_valid),
        .instr            (instr),
        .ctrl             (ctrl),
        .sr1              (sr1),
        .sr2              (sr2),
        .mdr              (mdr),
        .pc               (pc),
        .pcn              (pcn),
        .cc_in            (cc),
        .sr2_sel          (sr2_sel),
        .mem_addr         (mem_addr),
        .mem_wdata        (mem_wdata),
        .mem_write        (mem_write),
        .rf_load          (rf_load),
        .rf_dest          (rf_dest),
        .rf_data          (rf_data),
        .cc_out           (cc_new),
        .retire_valid     (retire_valid),
        .retire_pc        (retire_pc),
        .retire_reg_write (retire_reg_write),
        .retire_dest      (retire_dest),
        .retire_data      (retire_data),
        .retire_cc        (retire_cc)
    );

    data_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) u_data_memory (
        .clk   (clk),
        .write (mem_write),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mdr)
    );

    pc_unit u_pc_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .ctrl        (ctrl),
        .alu_out     (mem_addr),    // alu result doubles as jmp target
        .cc_new      (cc_new),
        .pc          (pc),
        .pcn         (pcn),
        .cc          (cc)
    );

endmodule : lc3b_exec

// File: hw/lc3b_types.sv
package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;    // n, z, p

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        lc3b_alu_op_pass,    // zero encoding, keep first
        lc3b_alu_op_add,
        lc3b_alu_op_and,
        lc3b_alu_op_not,
        lc3b_alu_op_sll,
        lc3b_alu_op_srl,
        lc3b_alu_op_sra
    } lc3b_alu_op;

    typedef enum logic [1:0] {
        lc3b_alu_mux_sel_sr2,
        lc3b_alu_mux_sel_imm5,
        lc3b_alu_mux_sel_imm4,
        lc3b_alu_mux_sel_offset6_w    // offset6 times two
    } lc3b_alu_mux_sel;

    typedef enum logic [1:0] {
        lc3b_pc_mux_sel_pc_plus2,
        lc3b_pc_mux_sel_pcn,
        lc3b_pc_mux_sel_alu
    } lc3b_pc_mux_sel;

    typedef enum logic {
        lc3b_pc_adder_mux_sel_offset9,
        lc3b_pc_adder_mux_sel_offset11
    } lc3b_pc_adder_mux_sel;

    typedef enum logic {
        lc3b_sr2_mux_sel_sr2,
        lc3b_sr2_mux_sel_dest    // stores read the source from the dest field
    } lc3b_sr2_mux_sel;

    typedef enum logic [1:0] {
        lc3b_data_mux_sel_alu,
        lc3b_data_mux_sel_mdr,
        lc3b_data_mux_sel_pcn,
        lc3b_data_mux_sel_pc    // pc plus 2, jsr link
    } lc3b_data_mux_sel;

    typedef enum logic {
        lc3b_dest_mux_sel_dest,
        lc3b_dest_mux_sel_r7
    } lc3b_dest_mux_sel;

    // all zero is a no-op that falls through to pc plus 2
    typedef struct packed {
        logic                 conditional_branch;
        lc3b_pc_mux_sel       pc_mux_sel;
        lc3b_pc_adder_mux_sel pc_adder_mux_sel;
        lc3b_sr2_mux_sel      sr2_mux_sel;
        lc3b_alu_mux_sel      alu_mux_sel;
        lc3b_alu_op           alu_op;
        logic                 cc_load;
        logic                 mem_write;
        lc3b_data_mux_sel     data_mux_sel;
        lc3b_dest_mux_sel     dest_mux_sel;
        logic                 regfile_load;
    } lc3b_control_word;

endpackage : lc3b_types

// File: hw/pc_unit.sv
module pc_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         instr_valid,
    input  lc3b_types::lc3b_word         instr,
    input  lc3b_types::lc3b_control_word ctrl,
    input  lc3b_types::lc3b_word         alu_out,
    input  lc3b_types::lc3b_nzp          cc_new,
    output lc3b_types::lc3b_word         pc,
    output lc3b_types::lc3b_word         pcn,
    output lc3b_types::lc3b_nzp          cc
);

    lc3b_types::lc3b_word pc_plus2;
    lc3b_types::lc3b_word offset;
    lc3b_types::lc3b_word pc_next;
    logic                 br_taken;

    assign pc_plus2 = pc + 16'd2;

    assign offset = (ctrl.pc_adder_mux_sel == lc3b_types::lc3b_pc_adder_mux_sel_offset11) ?
                    {{4{instr[10]}}, instr[10:0], 1'b0} :
                    {{6{instr[8]}}, instr[8:0], 1'b0};

    assign pcn = pc_plus2 + offset;

    assign br_taken = |(instr[11:9] & cc);    // any matching n/z/p bit

    always_comb begin
        case (ctrl.pc_mux_sel)
            lc3b_types::lc3b_pc_mux_sel_pcn:
                pc_next = (!ctrl.conditional_branch || br_taken) ? pcn : pc_plus2;
            lc3b_types::lc3b_pc_mux_sel_alu:
                pc_next = alu_out;
            default:
                pc_next = pc_plus2;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
            cc <= 3'b010;    // z after reset
        end else if (instr_valid) begin
            pc <= pc_next;
            if (ctrl.cc_load)
                cc <= cc_new;
        end
    end

    a_pc_even: assert property (@(posedge clk) disable iff (!rst_n) !pc[0])
        else $error("pc went odd: %h", pc);

endmodule : pc_unit

// File: hw/regfile.sv
module regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load,
    input  lc3b_types::lc3b_reg  dest_addr,
    input  lc3b_types::lc3b_reg  sr1_addr,
    input  lc3b_types::lc3b_reg  sr2_addr,
    input  lc3b_types::lc3b_word data_in,
    output lc3b_types::lc3b_word sr1_out,
    output lc3b_types::lc3b_word sr2_out
);

    lc3b_types::lc3b_word regs [8];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end else if (load) begin
            regs[dest_addr] <= data_in;
        end
    end

    // reads see the old value during a write cycle
    assign sr1_out = regs[sr1_addr];
    assign sr2_out = regs[sr2_addr];

endmodule : regfile

// File: lc3b_exec.f
hw/lc3b_types.sv
hw/control_rom.sv
hw/regfile.sv
hw/execute_unit.sv
hw/data_memory.sv
hw/pc_unit.sv
hw/lc3b_exec.sv
bench/lc3b_exec_checker.sv
bench/lc3b_exec_tb.sv
